//--- all.f
+incdir+rtl
rtl/rv_decode_pkg.sv
rtl/rv_imm_gen.sv
rtl/rv_alu_op_decode.sv
rtl/rv_ctrl_decode.sv
rtl/rv_decoder.sv
verif/rv_decoder_assert.sv
verif/tb_rv_decoder.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_rv_decoder
FLIST     ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000

SRCS := $(filter-out +%,$(shell cat $(FLIST)))
HDRS := $(wildcard rtl/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	-./$(BIN) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@grep -q -F '*** TEST PASSED ***' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verif/tb_rv_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_decode_config.svh"

module tb_rv_decoder import rv_decode_pkg::*; ();

   // funct7 of the three register classes base, alt (sub/sra) and muldiv
   localparam logic [6:0] CLASS_F7 [3] = '{7'b0000000, 7'b0100000, 7'b0000001};

   logic                   clk   = 1'b0;
   logic                   rst_n = 1'b0;
   logic                   en    = 1'b0;
   logic [`RV_INSTR_W-1:0] instr = '0;
   logic                   valid;
   reg_idx_t               regs;
   logic [`RV_XLEN-1:0]    imm;
   logic [2:0]             funct3;
   branch_mask_t           mask;
   exec_ctrl_t             ctrl;
   int unsigned            errors = 0;

   always #4 clk = ~clk;   // 8 ns period

   rv_decoder rv_decoder_i (
      .i_clk         (clk),
      .i_rst_n       (rst_n),
      .i_en          (en),
      .i_instr       (instr),
      .o_valid       (valid),
      .o_regs        (regs),
      .o_imm         (imm),
      .o_funct3      (funct3),
      .o_branch_mask (mask),
      .o_ctrl        (ctrl)
   );

   // r-type field slots that the other formats reuse for immediate bits
   function automatic logic [31:0] assemble(input logic [6:0] f7, input logic [4:0] rs2,
         input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input opcode_e opc);
      return {f7, rs2, rs1, f3, rd, opc, 2'b11};
   endfunction

   function automatic logic [31:0] upper(input logic [19:0] hi, input logic [4:0] rd,
         input opcode_e opc);
      return {hi, rd, opc, 2'b11};   // u and j formats
   endfunction

   function automatic logic [4:0] rand_reg();
      return 5'($urandom);
   endfunction

   function automatic logic [31:0] sext12(input logic [11:0] v);
      return {{20{v[11]}}, v};
   endfunction

   // flags in struct order from wb_from_alu down to write_reg
   function automatic exec_ctrl_t ctrl_of(input alu_op_e op, input src1_sel_e s1,
         input src2_sel_e s2, input reg_in_sel_e rin, input next_stage_e st,
         input logic [3:0] flags);
      return {op, s1, s2, rin, st, flags};
   endfunction

   // register form operation for a class index into CLASS_F7
   function automatic alu_op_e arith_op(input logic [1:0] cls, input logic [2:0] f3);
      alu_op_e base [8] = '{ALU_ADD, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL,
                            ALU_OR, ALU_AND};
      if (cls == 2'd2) return alu_op_e'(ALU_MUL + f3);
      if (cls == 2'd1 && f3 == 3'd0) return ALU_SUB;
      if (cls == 2'd1 && f3 == 3'd5) return ALU_SRA;
      return base[f3];
   endfunction

   task automatic check_val(input string name, input string what, input logic [31:0] exp,
         input logic [31:0] act);
      assert (exp === act) else begin
         $display("FAILED %s %s expected %h actual %h", name, what, exp, act);
         errors++;
      end
   endtask

   task automatic check_decode(input string name, input logic [31:0] w, input exec_ctrl_t ec,
         input branch_mask_t em, input logic [31:0] ei);
      check_val(name, "ctrl", 32'(ec), 32'(ctrl));
      check_val(name, "mask", 32'(em), 32'(mask));
      check_val(name, "imm", ei, imm);
      check_val(name, "regs", 32'({w[19:15], w[24:20], w[11:7]}), 32'(regs));
      check_val(name, "funct3", 32'(w[14:12]), 32'(funct3));
   endtask

   // one strobe, wait for the pulse, then check the decode and that it holds
   task automatic decode(input string name, input logic [31:0] w, input exec_ctrl_t ec,
         input branch_mask_t em, input logic [31:0] ei);
      int n;
      @(posedge clk);
      en    <= 1'b1;
      instr <= w;
      @(posedge clk);
      en    <= 1'b0;
      instr <= ~w;   // idle input differs from the captured word
      n = 0;
      @(negedge clk);
      while (!valid && n < 16) begin
         @(negedge clk);
         n++;
      end
      if (!valid) begin
         $display("no o_valid within 16 cycles of the strobe in %s", name);
         $display("*** TEST FAILED ***");
         $finish;
      end else begin
         check_decode(name, w, ec, em, ei);
         @(negedge clk);
         check_val({name, " hold"}, "valid", 32'd0, 32'(valid));
         check_decode({name, " hold"}, w, ec, em, ei);
      end
   endtask

   task automatic reset_state();
      for (int n = 0; n < 4; n++) begin
         @(negedge clk);
         check_val("reset", "valid", 32'd0, 32'(valid));
         check_val("reset", "ctrl", 32'd0, 32'(ctrl));
         check_val("reset", "mask", 32'd0, 32'(mask));
         check_val("reset", "imm", 32'd0, imm);
         check_val("reset", "regs", 32'd0, 32'(regs));
      end
   endtask

   task automatic reg_arith();
      logic [31:0] w;
      for (int c = 0; c < 3; c++) begin
         for (int f = 0; f < 8; f++) begin
            w = assemble(CLASS_F7[c], rand_reg(), rand_reg(), 3'(f), rand_reg(), OPC_OP);
            decode("reg_arith", w, ctrl_of(arith_op(2'(c), 3'(f)), SRC1_REGVAL1,
                   SRC2_REGVAL2, REGIN_ALU, STAGE_FETCH, 4'b1000), '0, sext12(w[31:20]));
         end
      end
   endtask

   task automatic imm_forms();
      logic [11:0] i12;
      logic [19:0] u20;
      logic [20:0] j;
      logic [2:0]  f3;
      alu_op_e     op;
      for (int k = 0; k < 16; k++) begin
         i12     = 12'($urandom);
         i12[10] = k[3];   // instr bit 30 picks srai over srli
         f3      = k[2:0];
         op      = (f3 == 3'd5 && i12[10]) ? ALU_SRA : arith_op(2'd0, f3);
         decode("opimm", assemble(i12[11:5], i12[4:0], rand_reg(), f3, rand_reg(), OPC_OPIMM),
                ctrl_of(op, SRC1_REGVAL1, SRC2_IMM, REGIN_ALU, STAGE_FETCH, 4'b1000), '0,
                sext12(i12));
      end
      for (int k = 0; k < 4; k++) begin
         i12 = 12'($urandom);
         u20 = 20'($urandom);
         j   = 21'($urandom) & ~21'd1;
         decode("store", assemble(i12[11:5], rand_reg(), rand_reg(), 3'd2, i12[4:0], OPC_STORE),
                ctrl_of(ALU_ADD, SRC1_REGVAL1, SRC2_IMM, REGIN_ALU, STAGE_STORE, 4'b0000), '0,
                sext12(i12));
         decode("lui", upper(u20, rand_reg(), OPC_LUI), ctrl_of(ALU_ADD, SRC1_REGVAL1,
                SRC2_REGVAL2, REGIN_IMM, STAGE_FETCH, 4'b0100), '0, {u20, 12'b0});
         decode("auipc", upper(u20, rand_reg(), OPC_AUIPC), ctrl_of(ALU_ADD, SRC1_PC,
                SRC2_IMM, REGIN_ALU, STAGE_FETCH, 4'b1000), '0, {u20, 12'b0});
         decode("jal", upper({j[20], j[10:1], j[11], j[19:12]}, rand_reg(), OPC_JAL),
                ctrl_of(ALU_ADD, SRC1_PC, SRC2_IMM, REGIN_ALU, STAGE_FETCH, 4'b0011), '0,
                {{11{j[20]}}, j});
      end
   endtask

   task automatic branch_masks();
      logic [2:0]  f3s [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};   // beq .. bgeu
      logic [12:0] b;
      exec_ctrl_t  ec;
      ec = ctrl_of(ALU_ADD, SRC1_REGVAL1, SRC2_REGVAL2, REGIN_ALU, STAGE_BRANCH, 4'b0000);
      for (int k = 0; k < 6; k++) begin
         b = 13'($urandom) & ~13'd1;
         decode("branch", assemble({b[12], b[10:5]}, rand_reg(), rand_reg(), f3s[k],
                {b[4:1], b[11]}, OPC_BRANCH), ec, branch_mask_t'(6'(1 << k)),
                {{19{b[12]}}, b});
      end
      decode("branch f3 010", assemble(7'd0, 5'd1, 5'd2, 3'b010, 5'd0, OPC_BRANCH), ec, '0,
             32'd0);
      decode("op f3 000", assemble(7'd0, 5'd1, 5'd2, 3'b000, 5'd3, OPC_OP),
             ctrl_of(ALU_ADD, SRC1_REGVAL1, SRC2_REGVAL2, REGIN_ALU, STAGE_FETCH, 4'b1000),
             '0, 32'd1);
   endtask

   task automatic ctrl_classes();
      logic [11:0] i12;
      logic [31:0] w;
      i12 = 12'($urandom);
      decode("load", assemble(i12[11:5], i12[4:0], rand_reg(), 3'b010, rand_reg(), OPC_LOAD),
             ctrl_of(ALU_ADD, SRC1_REGVAL1, SRC2_IMM, REGIN_ALU, STAGE_LOAD, 4'b0000), '0,
             sext12(i12));
      decode("jalr", assemble(i12[11:5], i12[4:0], rand_reg(), 3'b000, rand_reg(), OPC_JALR),
             ctrl_of(ALU_ADD, SRC1_REGVAL1, SRC2_IMM, REGIN_ALU, STAGE_FETCH, 4'b0011), '0,
             sext12(i12));
      decode("miscmem", assemble(7'd0, 5'd0, 5'd0, 3'b000, 5'd0, OPC_MISCMEM), ctrl_of(ALU_ADD,
             SRC1_REGVAL1, SRC2_REGVAL2, REGIN_ALU, STAGE_FETCH, 4'b0000), '0, 32'd0);
      decode("system", assemble(7'd0, 5'd1, 5'd0, 3'b000, 5'd0, OPC_SYSTEM), ctrl_of(ALU_ADD,
             SRC1_REGVAL1, SRC2_REGVAL2, REGIN_ALU, STAGE_SYSTEM, 4'b0000), '0, 32'd1);
      w = assemble(i12[11:5], i12[4:0], 5'd7, 3'b000, 5'd9, opcode_e'(5'b11010));  // reserved
      decode("unknown opcode", w, ctrl_of(ALU_ADD, SRC1_REGVAL1, SRC2_REGVAL2, REGIN_ALU,
             STAGE_TRAP, 4'b0000), '0, sext12(i12));
      w = assemble(7'h7f, 5'd3, 5'd4, 3'b000, 5'h1f, OPC_BRANCH) & ~32'h2;   // low bits 01
      decode("16-bit word", w, ctrl_of(ALU_ADD, SRC1_REGVAL1, SRC2_REGVAL2, REGIN_ALU,
             STAGE_TRAP, 4'b0000), '0, 32'd0);
   endtask

   // strobe every cycle and expect each result one cycle later
   task automatic back_to_back();
      logic [31:0] q [12];
      exec_ctrl_t  ec [12];
      int          c;
      int          f;
      for (int k = 0; k < 12; k++) begin
         c     = $urandom % 3;
         f     = $urandom % 8;
         q[k]  = assemble(CLASS_F7[c], rand_reg(), rand_reg(), 3'(f), rand_reg(), OPC_OP);
         ec[k] = ctrl_of(arith_op(2'(c), 3'(f)), SRC1_REGVAL1, SRC2_REGVAL2, REGIN_ALU,
                         STAGE_FETCH, 4'b1000);
      end
      for (int k = 0; k <= 12; k++) begin
         @(posedge clk);
         en <= (k < 12);
         if (k < 12) instr <= q[k];
         @(negedge clk);
         if (k > 0) begin
            check_val("back_to_back", "valid", 32'd1, 32'(valid));
            check_decode("back_to_back", q[k-1], ec[k-1], '0, sext12(q[k-1][31:20]));
         end
      end
   endtask

   initial begin
      int unsigned n_assert;
      void'($urandom(58054));
      repeat (8) @(posedge clk);
      rst_n <= 1'b1;
      reset_state();
      reg_arith();
      imm_forms();
      branch_masks();
      ctrl_classes();
      back_to_back();
      repeat (2) @(posedge clk);
      n_assert = rv_decoder_i.rv_decoder_assert_i.n_fail;
      $display("errors: %0d check(s), %0d assertion(s)", errors, n_assert);
      if (errors == 0 && n_assert == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire

//--- verif/rv_decoder_assert.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decoder_assert import rv_decode_pkg::*; (
   input wire logic         i_clk,
   input wire logic         i_rst_n,
   input wire logic         i_en,
   input wire logic         i_valid,
   input wire branch_mask_t i_branch_mask,
   input wire exec_ctrl_t   i_ctrl
);

   int unsigned n_fail = 0;   // number of failed assertions

   // valid is the strobe one edge later
   a_valid_follows_en: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_valid == $past(i_en))
      else begin
         $error("o_valid is not the previous cycle's i_en");
         n_fail++;
      end

   a_mask_onehot0: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      $onehot0(i_branch_mask))
      else begin
         $error("o_branch_mask has more than one bit set");
         n_fail++;
      end

   // a link write only happens on jumps
   a_link_is_jump: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_ctrl.write_reg |-> i_ctrl.next_pc_from_alu)
      else begin
         $error("write_reg set without next_pc_from_alu");
         n_fail++;
      end

endmodule

bind rv_decoder rv_decoder_assert rv_decoder_assert_i (
   .i_clk         (i_clk),
   .i_rst_n       (i_rst_n),
   .i_en          (i_en),
   .i_valid       (o_valid),
   .i_branch_mask (o_branch_mask),
   .i_ctrl        (o_ctrl)
);

`default_nettype wire

//--- rtl/rv_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_decode_config.svh"

module rv_decoder import rv_decode_pkg::*; (
   input  wire logic                   i_clk,
   input  wire logic                   i_rst_n,
   input  wire logic                   i_en,      // capture strobe
   input  wire logic [`RV_INSTR_W-1:0] i_instr,
   output      logic                   o_valid,
   output      reg_idx_t               o_regs,
   output      logic [`RV_XLEN-1:0]    o_imm,
   output      logic [2:0]             o_funct3,  // load/store width downstream
   output      branch_mask_t           o_branch_mask,
   output      exec_ctrl_t             o_ctrl
);

   reg_idx_t            regs_d;
   logic [`RV_XLEN-1:0] imm_d;
   exec_ctrl_t          ctrl_d;
   branch_mask_t        mask_d;

   // fixed field positions for every 32-bit format
   assign regs_d.rs1 = i_instr[19:15];
   assign regs_d.rs2 = i_instr[24:20];
   assign regs_d.rd  = i_instr[11:7];

   rv_imm_gen rv_imm_gen_i (
      .i_instr (i_instr),
      .o_imm   (imm_d)
   );

   rv_ctrl_decode rv_ctrl_decode_i (
      .i_instr       (i_instr),
      .o_ctrl        (ctrl_d),
      .o_branch_mask (mask_d)
   );

   // single output stage, loads only on the strobe
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_valid       <= 1'b0;
         o_regs        <= '0;
         o_imm         <= `RV_IMM_RST;
         o_funct3      <= `RV_FUNCT3_RST;
         o_branch_mask <= '0;
         o_ctrl        <= '0;   // stage fetch, all flags low
      end else begin
         o_valid <= i_en;   // one pulse per strobe
         if (i_en) begin
            o_regs        <= regs_d;
            o_imm         <= imm_d;
            o_funct3      <= i_instr[14:12];
            o_branch_mask <= mask_d;
            o_ctrl        <= ctrl_d;
         end
      end
   end

endmodule

`default_nettype wire

//--- rtl/rv_ctrl_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_decode_config.svh"

module rv_ctrl_decode import rv_decode_pkg::*; (
   input  wire logic [`RV_INSTR_W-1:0] i_instr,
   output      exec_ctrl_t             o_ctrl,
   output      branch_mask_t           o_branch_mask
);

   opcode_e opcode;
   funct3_e funct3;
   alu_op_e arith_op;   // from the funct3/funct7 subdecoder
   logic    is_32;      // low bits 11 marks a full-size word

   assign opcode = opcode_e'(i_instr[6:2]);
   assign funct3 = funct3_e'(i_instr[14:12]);
   assign is_32  = &i_instr[1:0];

   rv_alu_op_decode rv_alu_op_decode_i (
      .i_is_imm (opcode == OPC_OPIMM),
      .i_funct3 (funct3),
      .i_funct7 (i_instr[31:25]),
      .o_alu_op (arith_op)
   );

   always_comb begin
      o_ctrl            = '0;   // add, reg operands, no writeback
      o_ctrl.next_stage = STAGE_TRAP;
      if (is_32) begin
         case (opcode)
            OPC_OP, OPC_OPIMM: begin
               o_ctrl.alu_op      = arith_op;
               o_ctrl.src2_sel    = (opcode == OPC_OP) ? SRC2_REGVAL2 : SRC2_IMM;
               o_ctrl.wb_from_alu = 1'b1;   // rd written back in fetch
               o_ctrl.next_stage  = STAGE_FETCH;
            end
            OPC_LOAD, OPC_STORE: begin
               // address = rs1 + imm on the alu
               o_ctrl.alu_op     = ALU_ADD;
               o_ctrl.src2_sel   = SRC2_IMM;
               o_ctrl.next_stage = (opcode == OPC_LOAD) ? STAGE_LOAD : STAGE_STORE;
            end
            OPC_JAL, OPC_JALR: begin
               o_ctrl.write_reg        = 1'b1;   // link address
               o_ctrl.reg_in_sel       = REGIN_ALU;
               o_ctrl.alu_op           = ALU_ADD;
               o_ctrl.src1_sel         = (opcode == OPC_JAL) ? SRC1_PC : SRC1_REGVAL1;
               o_ctrl.src2_sel         = SRC2_IMM;
               o_ctrl.next_pc_from_alu = 1'b1;   // target from alu
               o_ctrl.next_stage       = STAGE_FETCH;
            end
            OPC_BRANCH: begin
               o_ctrl.alu_op     = ALU_ADD;   // compare done by branch unit
               o_ctrl.src2_sel   = SRC2_REGVAL2;
               o_ctrl.next_stage = STAGE_BRANCH;
            end
            OPC_AUIPC: begin
               o_ctrl.alu_op      = ALU_ADD;
               o_ctrl.src1_sel    = SRC1_PC;
               o_ctrl.src2_sel    = SRC2_IMM;
               o_ctrl.wb_from_alu = 1'b1;
               o_ctrl.next_stage  = STAGE_FETCH;
            end
            OPC_LUI: begin
               o_ctrl.wb_from_imm = 1'b1;
               o_ctrl.reg_in_sel  = REGIN_IMM;
               o_ctrl.next_stage  = STAGE_FETCH;
            end
            OPC_MISCMEM: o_ctrl.next_stage = STAGE_FETCH;   // fence is a nop here
            OPC_SYSTEM:  o_ctrl.next_stage = STAGE_SYSTEM;
            default:     o_ctrl.next_stage = STAGE_TRAP;
         endcase
      end
   end

   // one-hot condition, only for real branches
   always_comb begin
      o_branch_mask = '0;
      if (is_32 && opcode == OPC_BRANCH) begin
         case (funct3)
            F3_BEQ:  o_branch_mask.beq  = 1'b1;
            F3_BNE:  o_branch_mask.bne  = 1'b1;
            F3_BLT:  o_branch_mask.blt  = 1'b1;
            F3_BGE:  o_branch_mask.bge  = 1'b1;
            F3_BLTU: o_branch_mask.bltu = 1'b1;
            F3_BGEU: o_branch_mask.bgeu = 1'b1;
            default: o_branch_mask      = '0;   // 010, 011 reserved
         endcase
      end
   end

endmodule

`default_nettype wire

//--- rtl/rv_alu_op_decode.sv
`timescale 1ns/1ps
`default_nettype none

module rv_alu_op_decode import rv_decode_pkg::*; (
   input  wire logic    i_is_imm,   // opimm form, funct7 is part of the immediate
   input  wire funct3_e i_funct3,
   input  wire logic [6:0] i_funct7,
   output      alu_op_e o_alu_op
);

   localparam logic [6:0] F7_ALT    = 7'b0100000;   // sub / sra
   localparam logic [6:0] F7_MULDIV = 7'b0000001;

   alu_op_e base_op;
   alu_op_e md_op;
   logic    alt;

   // shift immediates only look at bit 30
   assign alt = i_is_imm ? i_funct7[5] : (i_funct7 == F7_ALT);

   always_comb begin
      case (i_funct3)
         F3_ADD_SUB: base_op = (alt && !i_is_imm) ? ALU_SUB : ALU_ADD;   // no subi
         F3_SLL:     base_op = ALU_SLL;
         F3_SLT:     base_op = ALU_SLT;
         F3_SLTU:    base_op = ALU_SLTU;
         F3_XOR:     base_op = ALU_XOR;
         F3_SRL_SRA: base_op = alt ? ALU_SRA : ALU_SRL;
         F3_OR:      base_op = ALU_OR;
         F3_AND:     base_op = ALU_AND;
         default:    base_op = ALU_ADD;
      endcase
   end

   // M extension, same funct3 order as the spec table
   always_comb begin
      case (i_funct3)
         F3_ADD_SUB: md_op = ALU_MUL;
         F3_SLL:     md_op = ALU_MULH;
         F3_SLT:     md_op = ALU_MULHSU;
         F3_SLTU:    md_op = ALU_MULHU;
         F3_XOR:     md_op = ALU_DIV;
         F3_SRL_SRA: md_op = ALU_DIVU;
         F3_OR:      md_op = ALU_REM;
         F3_AND:     md_op = ALU_REMU;
         default:    md_op = ALU_MUL;
      endcase
   end

   always_comb begin
      if (!i_is_imm && i_funct7 == F7_MULDIV) begin
         o_alu_op = md_op;
      end else begin
         o_alu_op = base_op;   // other funct7 values fall back to base op
      end
   end

endmodule

`default_nettype wire

//--- rtl/rv_imm_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_decode_config.svh"

module rv_imm_gen import rv_decode_pkg::*; (
   input  wire logic [`RV_INSTR_W-1:0] i_instr,
   output      logic [`RV_XLEN-1:0]    o_imm
);

   opcode_e opcode;
   logic    sign;   // all signed layouts extend from bit 31

   assign opcode = opcode_e'(i_instr[6:2]);
   assign sign   = i_instr[31];

   always_comb begin
      if (i_instr[1:0] != 2'b11) begin
         o_imm = '0;   // compressed or reserved encoding
      end else begin
         case (opcode)
            OPC_STORE:   // S-type
               o_imm = {{(`RV_XLEN-12){sign}}, i_instr[31:25], i_instr[11:7]};
            OPC_BRANCH: begin
               // B-type, offset in halfwords
               o_imm = {{(`RV_XLEN-12){sign}}, i_instr[7], i_instr[30:25],
                        i_instr[11:8], 1'b0};
            end
            OPC_LUI, OPC_AUIPC:
               o_imm = {i_instr[31:12], 12'b0};   // U-type, no extension needed
            OPC_JAL: begin
               // J-type
               o_imm = {{(`RV_XLEN-20){sign}}, i_instr[19:12], i_instr[20],
                        i_instr[30:21], 1'b0};
            end
            default:   // I-type, meaningless for R-type but harmless
               o_imm = {{(`RV_XLEN-12){sign}}, i_instr[31:20]};
         endcase
      end
   end

endmodule

`default_nettype wire

//--- rtl/rv_decode_pkg.sv
`default_nettype none

`include "rv_decode_config.svh"

package rv_decode_pkg;

   // major opcode, instr[6:2]
   typedef enum logic [4:0] {
      OPC_LOAD    = 5'b00000,
      OPC_MISCMEM = 5'b00011,   // fence
      OPC_OPIMM   = 5'b00100,
      OPC_AUIPC   = 5'b00101,
      OPC_STORE   = 5'b01000,
      OPC_OP      = 5'b01100,
      OPC_LUI     = 5'b01101,
      OPC_BRANCH  = 5'b11000,
      OPC_JALR    = 5'b11001,
      OPC_JAL     = 5'b11011,
      OPC_SYSTEM  = 5'b11100
   } opcode_e;

   // funct3 for OP / OPIMM
   typedef enum logic [2:0] {
      F3_ADD_SUB = 3'b000,
      F3_SLL     = 3'b001,
      F3_SLT     = 3'b010,
      F3_SLTU    = 3'b011,
      F3_XOR     = 3'b100,
      F3_SRL_SRA = 3'b101,
      F3_OR      = 3'b110,
      F3_AND     = 3'b111
   } funct3_e;

   // branch names share the encodings above, so they are constants of the same type
   localparam funct3_e F3_BEQ  = funct3_e'(3'b000);
   localparam funct3_e F3_BNE  = funct3_e'(3'b001);
   localparam funct3_e F3_BLT  = funct3_e'(3'b100);
   localparam funct3_e F3_BGE  = funct3_e'(3'b101);
   localparam funct3_e F3_BLTU = funct3_e'(3'b110);
   localparam funct3_e F3_BGEU = funct3_e'(3'b111);

   typedef enum logic [4:0] {
      ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
      ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
      ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU,   // M extension
      ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU
   } alu_op_e;

   typedef enum logic       {SRC1_REGVAL1 = 1'b0, SRC1_PC  = 1'b1} src1_sel_e;
   typedef enum logic [1:0] {SRC2_REGVAL2 = 2'd0, SRC2_IMM = 2'd1} src2_sel_e;
   typedef enum logic [1:0] {REGIN_ALU    = 2'd0, REGIN_IMM = 2'd1} reg_in_sel_e;

   // FETCH must stay zero, it is the reset state of the control word
   typedef enum logic [2:0] {
      STAGE_FETCH  = 3'd0,
      STAGE_LOAD   = 3'd1,
      STAGE_STORE  = 3'd2,
      STAGE_BRANCH = 3'd3,
      STAGE_SYSTEM = 3'd4,
      STAGE_TRAP   = 3'd5
   } next_stage_e;

   typedef struct packed {
      logic [`RV_REG_IDX_W-1:0] rs1;
      logic [`RV_REG_IDX_W-1:0] rs2;
      logic [`RV_REG_IDX_W-1:0] rd;
   } reg_idx_t;

   typedef struct packed {
      alu_op_e     alu_op;
      src1_sel_e   src1_sel;
      src2_sel_e   src2_sel;
      reg_in_sel_e reg_in_sel;
      next_stage_e next_stage;
      logic        wb_from_alu;       // rd <= alu result in fetch
      logic        wb_from_imm;       // rd <= imm (lui)
      logic        next_pc_from_alu;  // jumps
      logic        write_reg;         // link register write
   } exec_ctrl_t;

   // listed msb first so beq lands on bit 0
   typedef struct packed {
      logic bgeu;
      logic bltu;
      logic bge;
      logic blt;
      logic bne;
      logic beq;
   } branch_mask_t;

endpackage

`default_nettype wire

//--- rtl/rv_decode_config.svh
`ifndef RV_DECODE_CONFIG_SVH
`define RV_DECODE_CONFIG_SVH

// datapath and immediate width
`define RV_XLEN        32
`define RV_REG_IDX_W   5    // x0..x31
`define RV_INSTR_W     32   // only full-size words, no compressed set

// output register values after reset
`define RV_IMM_RST     32'h0000_0000
`define RV_FUNCT3_RST  3'b000

`endif
